/* peak_sync_top.f */
rtl/sync_pkg.sv
rtl/iq_power_gate.sv
rtl/peak_detect.sv
rtl/peak_report.sv
rtl/peak_sync_top.sv
verif/tb_clock.sv
verif/peak_sync_tb.sv

/* rtl/iq_power_gate.sv */
`timescale 1ns/1ps

module iq_power_gate (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_clear,
  input  logic                              i_valid,
  input  logic signed [sync_pkg::IQ_W-1:0]  i_i,
  input  logic signed [sync_pkg::IQ_W-1:0]  i_q,
  input  logic                              i_last,
  output logic                              o_ready,
  input  logic        [sync_pkg::POW_W-1:0] i_threshold,
  output logic                              o_valid,
  output logic        [sync_pkg::POW_W-1:0] o_power,
  output logic                              o_flag,
  output logic                              o_last,
  input  logic                              i_ready
);

  logic signed [2*sync_pkg::IQ_W-1:0] i_sq;
  logic signed [2*sync_pkg::IQ_W-1:0] q_sq;
  logic        [sync_pkg::POW_W-1:0]  power;
  logic                               take;

  // squares are never negative, so the sum is done unsigned
  assign i_sq  = i_i * i_i;
  assign q_sq  = i_q * i_q;
  assign power = sync_pkg::POW_W'($unsigned(i_sq)) + sync_pkg::POW_W'($unsigned(q_sq));

  assign o_ready = i_ready | ~o_valid;
  assign take    = i_valid & o_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (i_clear) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      o_power <= power;
      o_flag  <= (power >= i_threshold);
      o_last  <= i_last;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a stalled beat holds its payload until the detector takes it
  a_hold_stall : assert property (
    @(posedge clk) disable iff (!i_arst_n || i_clear)
    o_valid && !i_ready |=>
      o_valid && $stable(o_power) && $stable(o_flag) && $stable(o_last)
  );

endmodule

/* rtl/peak_detect.sv */
`timescale 1ns/1ps

module peak_detect (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_clear,
  input  logic                       i_valid,
  input  logic [sync_pkg::POW_W-1:0] i_power,
  input  logic                       i_flag,
  input  logic                       i_last,
  output logic                       o_ready,
  output logic                       o_valid,
  output logic                       o_last,
  output logic                       o_peak,
  input  logic                       i_ready
);

  sync_pkg::det_state_t             state;
  logic [sync_pkg::POW_W-1:0]       max_pow;
  logic [3:0]                       rise_hist;
  logic [sync_pkg::CNT_W-1:0]       quiet_cnt;
  logic                             take;
  logic                             search_done;

  assign o_ready     = i_ready | ~o_valid;
  assign take        = i_valid & o_ready;
  assign search_done = (quiet_cnt >= sync_pkg::CNT_W'(sync_pkg::NRX_TRIG));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // running-max FSM, advances only on accepted beats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= sync_pkg::INIT;
      rise_hist <= '0;
      quiet_cnt <= '0;
      o_peak    <= 1'b0;
      o_valid   <= 1'b0;
    end else if (i_clear) begin
      state     <= sync_pkg::INIT;
      rise_hist <= '0;
      quiet_cnt <= '0;
      o_peak    <= 1'b0;
      o_valid   <= 1'b0;
    end else begin
      if (o_ready) begin
        o_valid <= i_valid;
      end
      if (take) begin
        case (state)
          sync_pkg::INIT: begin
            rise_hist <= '0;
            quiet_cnt <= '0;
            o_peak    <= 1'b0;
            if (i_flag) begin
              state <= sync_pkg::TRIG;
            end
          end
          sync_pkg::TRIG: begin
            if (search_done) begin
              quiet_cnt <= '0;
              state     <= sync_pkg::WAIT;
              // four rises in a row and still above threshold
              o_peak    <= (&rise_hist) & i_flag;
            end else if (i_power > max_pow) begin
              rise_hist <= {rise_hist[2:0], 1'b1};
              quiet_cnt <= '0;
            end else begin
              quiet_cnt <= quiet_cnt + 1'b1;
            end
          end
          sync_pkg::WAIT: state <= sync_pkg::IDLE;
          sync_pkg::IDLE: state <= sync_pkg::INIT;
          default:        state <= sync_pkg::INIT;
        endcase
      end
    end
  end

  // running maximum and marker last flag
  always_ff @(posedge clk) begin
    if (take) begin
      o_last <= i_last;
      if (state == sync_pkg::INIT) begin
        max_pow <= i_power;
      end else if (state == sync_pkg::TRIG && !search_done && i_power > max_pow) begin
        max_pow <= i_power;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // quiet count stays in range and only runs during a search
  a_state_legal : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (quiet_cnt <= sync_pkg::CNT_W'(sync_pkg::NRX_TRIG)) &&
      (state == sync_pkg::TRIG || quiet_cnt == '0)
  );

  // peak strobe only comes from the beat that ends a search
  a_peak_from_trig : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    $rose(o_peak) |-> $past(take && state == sync_pkg::TRIG)
  );

endmodule

/* rtl/peak_report.sv */
`timescale 1ns/1ps

module peak_report (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_clear,
  input  logic                       i_valid,
  input  logic                       i_last,
  input  logic                       i_peak,
  output logic                       o_ready,
  output logic                       o_rep_valid,
  output logic [sync_pkg::IDX_W-1:0] o_rep_index,
  output logic [sync_pkg::FRM_W-1:0] o_rep_frame,
  input  logic                       i_rep_ready
);

  logic [sync_pkg::IDX_W-1:0] idx;
  logic [sync_pkg::FRM_W-1:0] frm;
  logic                       prev_peak;
  logic                       take;
  logic                       new_rep;

  // held report blocks the marker stream until it is taken
  assign o_ready = ~o_rep_valid | i_rep_ready;
  assign take    = i_valid & o_ready;
  assign new_rep = take & i_peak & ~prev_peak;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      idx         <= '0;
      frm         <= '0;
      prev_peak   <= 1'b0;
      o_rep_valid <= 1'b0;
    end else if (i_clear) begin
      idx         <= '0;
      frm         <= '0;
      prev_peak   <= 1'b0;
      o_rep_valid <= 1'b0;
    end else begin
      if (take) begin
        prev_peak <= i_peak;
        if (i_last) begin
          idx <= '0;
          frm <= frm + 1'b1;
        end else begin
          idx <= idx + 1'b1;
        end
      end
      if (new_rep) begin
        o_rep_valid <= 1'b1;
      end else if (i_rep_ready) begin
        o_rep_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (new_rep) begin
      o_rep_index <= idx;
      o_rep_frame <= frm;
    end
  end

  a_rep_hold : assert property (
    @(posedge clk) disable iff (!i_arst_n || i_clear)
    o_rep_valid && !i_rep_ready |=> o_rep_valid
  );

endmodule

/* rtl/peak_sync_top.sv */
`timescale 1ns/1ps

module peak_sync_top (
  input  logic                             clk,
  input  logic                             i_arst_n,
  input  logic                             i_clear,
  input  logic        [sync_pkg::POW_W-1:0] i_threshold,
  input  logic                             i_iq_valid,
  input  logic signed [sync_pkg::IQ_W-1:0]  i_iq_i,
  input  logic signed [sync_pkg::IQ_W-1:0]  i_iq_q,
  input  logic                             i_iq_last,
  output logic                             o_iq_ready,
  output logic                             o_rep_valid,
  output logic        [sync_pkg::IDX_W-1:0] o_rep_index,
  output logic        [sync_pkg::FRM_W-1:0] o_rep_frame,
  input  logic                             i_rep_ready
);

  // power stream
  logic                       pw_valid;
  logic [sync_pkg::POW_W-1:0] pw_power;
  logic                       pw_flag;
  logic                       pw_last;
  logic                       pw_ready;

  // marker stream
  logic                       mk_valid;
  logic                       mk_last;
  logic                       mk_peak;
  logic                       mk_ready;

  iq_power_gate u_gate (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_valid(i_iq_valid), .i_i(i_iq_i), .i_q(i_iq_q), .i_last(i_iq_last),
    .o_ready(o_iq_ready), .i_threshold(i_threshold),
    .o_valid(pw_valid), .o_power(pw_power), .o_flag(pw_flag), .o_last(pw_last),
    .i_ready(pw_ready)
  );

  peak_detect u_detect (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_valid(pw_valid), .i_power(pw_power), .i_flag(pw_flag), .i_last(pw_last),
    .o_ready(pw_ready),
    .o_valid(mk_valid), .o_last(mk_last), .o_peak(mk_peak), .i_ready(mk_ready)
  );

  peak_report u_report (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_valid(mk_valid), .i_last(mk_last), .i_peak(mk_peak), .o_ready(mk_ready),
    .o_rep_valid(o_rep_valid), .o_rep_index(o_rep_index),
    .o_rep_frame(o_rep_frame), .i_rep_ready(i_rep_ready)
  );

endmodule

/* rtl/sync_pkg.sv */
package sync_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // signed I and Q component
  localparam int IQ_W  = 8;
  // I^2 + Q^2 tops out at 2 * 128^2 = 32768
  localparam int POW_W = 16;
  // sample index within a frame, frames up to 256 samples
  localparam int IDX_W = 8;
  // frame counter, wraps
  localparam int FRM_W = 8;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // peak search
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // quiet samples without a new maximum that end the search
  localparam int NRX_TRIG = 16;
  // must hold NRX_TRIG
  localparam int CNT_W    = 5;

  typedef enum logic [1:0] {
    INIT = 2'b00,
    WAIT = 2'b01,
    TRIG = 2'b10,
    IDLE = 2'b11
  } det_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the peak finder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module peak_sync_tb -Mdir obj_dir -f peak_sync_top.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vpeak_sync_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi
exit 0

/* verif/peak_cases.txt */
# t threshold | s count i q last stall (last on the final repeat) | c clear pulse
# r index frame of an expected report, in order; NRX_TRIG is 16
t 100
# frame 0: five rises, 17 lower beats, report at index 22
s 1 11 0 0 0
s 1 12 0 0 0
s 1 13 0 0 0
s 1 14 0 0 0
s 1 15 0 0 0
s 1 16 0 0 0
s 17 12 0 0 0
s 5 1 0 1 0
r 22 0
# frame 1: three rises only
s 1 11 0 0 0
s 1 12 0 0 0
s 1 13 0 0 0
s 1 14 0 0 0
s 17 12 0 0 0
s 3 1 0 1 0
# frame 2: flag low on the beat that ends the search
s 1 11 0 0 0
s 1 12 0 0 0
s 1 13 0 0 0
s 1 14 0 0 0
s 1 15 0 0 0
s 1 16 0 0 0
s 16 12 0 0 0
s 1 1 0 0 0
s 3 1 0 1 0
# frame 3: below threshold throughout
s 10 3 0 1 0
# frame 4: report stalled downstream
s 1 11 0 0 1
s 1 12 0 0 1
s 1 13 0 0 1
s 1 14 0 0 1
s 1 15 0 0 1
s 1 16 0 0 1
s 17 12 0 0 1
s 5 1 0 1 1
r 22 4
# frame 5 cut short by a clear during the search
s 1 11 0 0 0
s 1 16 0 0 0
s 4 12 0 0 0
c
# counting restarts at frame 0
s 1 11 0 0 0
s 1 12 0 0 0
s 1 13 0 0 0
s 1 14 0 0 0
s 1 15 0 0 0
s 1 16 0 0 0
s 17 12 0 1 0
r 22 0

/* verif/peak_sync_tb.sv */
`timescale 1ns/1ps

module peak_sync_tb;

  logic                              clk;
  logic                              i_arst_n;
  logic                              i_clear;
  logic        [sync_pkg::POW_W-1:0] i_threshold;
  logic                              i_iq_valid;
  logic signed [sync_pkg::IQ_W-1:0]  i_iq_i;
  logic signed [sync_pkg::IQ_W-1:0]  i_iq_q;
  logic                              i_iq_last;
  logic                              o_iq_ready;
  logic                              o_rep_valid;
  logic        [sync_pkg::IDX_W-1:0] o_rep_index;
  logic        [sync_pkg::FRM_W-1:0] o_rep_frame;
  logic                              i_rep_ready;

  // one entry per input beat, expanded from the cases file
  logic signed [sync_pkg::IQ_W-1:0]  beat_i[$];
  logic signed [sync_pkg::IQ_W-1:0]  beat_q[$];
  bit                                beat_last[$];
  bit                                beat_stall[$];
  bit                                beat_clear[$];
  logic        [sync_pkg::IDX_W-1:0] exp_idx[$];
  logic        [sync_pkg::FRM_W-1:0] exp_frm[$];

  integer seed;
  int     cycles;
  int     limit;
  bit     refused;
  bit     want_refuse;
  bit     accepted;

  tb_clock clk_gen (.o_clk(clk));

  peak_sync_top dut0 (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear), .i_threshold(i_threshold),
    .i_iq_valid(i_iq_valid), .i_iq_i(i_iq_i), .i_iq_q(i_iq_q), .i_iq_last(i_iq_last),
    .o_iq_ready(o_iq_ready), .o_rep_valid(o_rep_valid), .o_rep_index(o_rep_index),
    .o_rep_frame(o_rep_frame), .i_rep_ready(i_rep_ready)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_index(input logic [sync_pkg::IDX_W-1:0] got,
                             input logic [sync_pkg::IDX_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL o_rep_index got %h expected %h", got, exp));
    end
  endtask

  task automatic check_frame(input logic [sync_pkg::FRM_W-1:0] got,
                             input logic [sync_pkg::FRM_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL o_rep_frame got %h expected %h", got, exp));
    end
  endtask

  task automatic read_cases();
    int                   fd;
    int                   code;
    int                   cnt;
    int                   vi;
    int                   vq;
    int                   vl;
    int                   vs;
    logic [8*8-1:0]       kind;
    string                line;
    fd = $fopen("verif/peak_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the cases file verif/peak_cases.txt");
    end
    while (!$feof(fd)) begin
      kind = '0;
      code = $fscanf(fd, "%s", kind);
      if (code != 1) begin
        break;
      end
      if (kind == "#") begin
        code = $fgets(line, fd);
      end else if (kind == "t") begin
        code = $fscanf(fd, "%d", vi);
        i_threshold = sync_pkg::POW_W'(vi);
      end else if (kind == "s") begin
        code = $fscanf(fd, "%d %d %d %d %d", cnt, vi, vq, vl, vs);
        for (int k = 0; k < cnt; k++) begin
          beat_i.push_back(sync_pkg::IQ_W'(vi));
          beat_q.push_back(sync_pkg::IQ_W'(vq));
          beat_last.push_back(vl != 0 && k == cnt - 1);
          beat_stall.push_back(vs != 0);
          beat_clear.push_back(1'b0);
          if (vs != 0) want_refuse = 1'b1;
        end
      end else if (kind == "c") begin
        beat_i.push_back('0);
        beat_q.push_back('0);
        beat_last.push_back(1'b0);
        beat_stall.push_back(1'b0);
        beat_clear.push_back(1'b1);
      end else if (kind == "r") begin
        code = $fscanf(fd, "%d %d", vi, vq);
        exp_idx.push_back(sync_pkg::IDX_W'(vi));
        exp_frm.push_back(sync_pkg::FRM_W'(vq));
      end else begin
        abort_run("unknown line kind in the cases file");
      end
    end
    $fclose(fd);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // report monitor and timeout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    if (i_arst_n) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
        abort_run("timeout: the run did not finish, an expected report never came");
      end
      if (!o_iq_ready) refused = 1'b1;
      if (o_rep_valid && i_rep_ready) begin
        if (exp_idx.size() == 0) begin
          abort_run("a report came out although none was expected");
        end
        check_index(o_rep_index, exp_idx.pop_front());
        check_frame(o_rep_frame, exp_frm.pop_front());
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    seed        = 32'hd067_d9c9;
    cycles      = 0;
    refused     = 1'b0;
    want_refuse = 1'b0;
    i_arst_n    = 1'b0;
    i_clear     = 1'b0;
    i_threshold = '0;
    i_iq_valid  = 1'b0;
    i_iq_i      = '0;
    i_iq_q      = '0;
    i_iq_last   = 1'b0;
    i_rep_ready = 1'b1;
    read_cases();
    limit = 4 * beat_i.size() + 100;
    repeat (10) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;
    for (int n = 0; n < beat_i.size(); n++) begin
      if (beat_clear[n]) begin
        i_iq_valid  = 1'b0;
        i_rep_ready = 1'b1;
        i_clear     = 1'b1;
        @(negedge clk);
        i_clear = 1'b0;
      end else begin
        // random idle gaps only on stalled lines
        while (beat_stall[n] && ($random(seed) & 3) == 0) begin
          i_iq_valid  = 1'b0;
          i_rep_ready = (($random(seed) & 15) == 0);
          @(negedge clk);
        end
        i_iq_valid = 1'b1;
        i_iq_i     = beat_i[n];
        i_iq_q     = beat_q[n];
        i_iq_last  = beat_last[n];
        do begin
          i_rep_ready = beat_stall[n] ? (($random(seed) & 15) == 0) : 1'b1;
          @(posedge clk);
          accepted = o_iq_ready;
          @(negedge clk);
        end while (!accepted);
      end
    end
    i_iq_valid  = 1'b0;
    i_iq_last   = 1'b0;
    i_rep_ready = 1'b1;
    while (exp_idx.size() != 0) @(negedge clk);
    // room for a stray report to show up
    repeat (20) @(negedge clk);
    if (want_refuse && !refused) begin
      abort_run("input was never refused while reports were stalled");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk
);

  // 20 ns period
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

endmodule
